/* Makefile */
# Verilator flow for the fixed-point ALU

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_alu
DUT_TOP   ?= alu_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Q6.10 word layout
`define ALU_INT_W           6
`define ALU_FRAC_W          10
`define ALU_DATA_W          (`ALU_INT_W + `ALU_FRAC_W)

`define ALU_OP_W            4       // opcode field

// lfsr step control, upper steps clamp to the max
`define ALU_LFSR_CNT_W      4
`define ALU_LFSR_MAX_STEPS  8

// feedback taps for x^16 + x^14 + x^13 + x^11 + 1
`define ALU_LFSR_TAP_A      15
`define ALU_LFSR_TAP_B      13
`define ALU_LFSR_TAP_C      12
`define ALU_LFSR_TAP_D      10

`endif

/* alu_pkg.sv */
`include "alu_defs.svh"

package alu_pkg;

    typedef logic signed [`ALU_DATA_W-1:0] alu_data_t;   // Q6.10

    typedef enum logic [`ALU_OP_W-1:0] {
        OP_ADD_FX = 4'd0,
        OP_SUB_FX = 4'd1,
        OP_MUL_FX = 4'd2,
        OP_MAC    = 4'd3,
        OP_CLZ    = 4'd5,
        OP_LRCW   = 4'd6,
        OP_LFSR   = 4'd7
    } alu_op_e;

    // fixed control loop, one clock per state
    typedef enum logic [1:0] {
        IDLE = 2'b00,   // after reset only
        WAIT = 2'b01,
        OPER = 2'b10,
        OUT  = 2'b11    // result captured at end of this state
    } alu_state_e;

    typedef struct packed {
        logic [`ALU_INT_W-1:0]  int_part;
        logic [`ALU_FRAC_W-1:0] frac_part;
    } alu_fx_s;

    typedef struct packed {
        logic [`ALU_DATA_W-`ALU_LFSR_CNT_W-1:0] pad;
        logic [`ALU_LFSR_CNT_W-1:0]            lfsr_steps;
    } alu_ctl_s;

    // operand b, fixed-point value or lfsr step count
    typedef union packed {
        alu_fx_s  fx;
        alu_ctl_s ctl;
    } alu_operand_u;

endpackage

/* alu_result_stage.sv */
`timescale 1ns/1ps

module alu_result_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_capture,
    input  alu_pkg::alu_op_e  i_inst,
    input  alu_pkg::alu_data_t i_add,
    input  alu_pkg::alu_data_t i_sub,
    input  alu_pkg::alu_data_t i_mul,
    input  alu_pkg::alu_data_t i_mac,
    input  alu_pkg::alu_data_t i_clz,
    input  alu_pkg::alu_data_t i_lrcw,
    input  alu_pkg::alu_data_t i_lfsr,
    output alu_pkg::alu_data_t o_data
);

    import alu_pkg::*;

    alu_data_t sel_data;

    // opcode decode
    always_comb begin
        case (i_inst)
            OP_ADD_FX: sel_data = i_add;
            OP_SUB_FX: sel_data = i_sub;
            OP_MUL_FX: sel_data = i_mul;
            OP_MAC:    sel_data = i_mac;
            OP_CLZ:    sel_data = i_clz;
            OP_LRCW:   sel_data = i_lrcw;
            OP_LFSR:   sel_data = i_lfsr;
            default:   sel_data = '0;       // 4, 8, 9 and spare codes
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data <= '0;
        end else if (i_capture) begin
            o_data <= sel_data;     // held until next OUT
        end
    end

endmodule

/* alu_sequencer.sv */
`timescale 1ns/1ps

module alu_sequencer (
    input  logic i_clk,
    input  logic i_rst_n,
    output logic o_capture,
    output logic o_busy,
    output logic o_valid
);

    import alu_pkg::*;

    alu_state_e state_q;
    alu_state_e state_d;
    logic       start_q;    // set once busy has been seen low

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        case (state_q)
            IDLE:    state_d = WAIT;
            WAIT:    state_d = OPER;
            OPER:    state_d = OUT;
            OUT:     state_d = WAIT;    // steady loop of 3
            default: state_d = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control levels
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_capture <= 1'b0;
            o_busy    <= 1'b1;                  // busy during reset
            o_valid   <= 1'b0;
            start_q   <= 1'b0;
        end else begin
            o_capture <= (state_d == OUT);      // high exactly in OUT
            o_busy    <= ~o_capture;            // low one cycle after OUT
            o_valid   <= o_capture & start_q;   // first result not flagged
            start_q   <= start_q | ~o_busy;
        end
    end

endmodule

/* alu_top.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  alu_pkg::alu_data_t   i_data_a,
    input  alu_pkg::alu_data_t   i_data_b,
    input  logic [`ALU_OP_W-1:0] i_inst,
    output logic                 o_valid,
    output logic                 o_busy,
    output alu_pkg::alu_data_t   o_data
);

    import alu_pkg::*;

    logic      capture;
    alu_data_t add_res;
    alu_data_t sub_res;
    alu_data_t mul_res;
    alu_data_t mac_res;
    alu_data_t clz_res;
    alu_data_t lrcw_res;
    alu_data_t lfsr_res;

    alu_sequencer u_sequencer (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .o_capture (capture),
        .o_busy    (o_busy),
        .o_valid   (o_valid)
    );

    fx_arith_unit u_fx_arith (
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .i_acc    (o_data),     // mac feedback
        .o_add    (add_res),
        .o_sub    (sub_res),
        .o_mul    (mul_res),
        .o_mac    (mac_res)
    );

    bit_manip_unit u_bit_manip (
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .o_clz    (clz_res),
        .o_lrcw   (lrcw_res),
        .o_lfsr   (lfsr_res)
    );

    alu_result_stage u_result_stage (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_capture (capture),
        .i_inst    (alu_op_e'(i_inst)),
        .i_add     (add_res),
        .i_sub     (sub_res),
        .i_mul     (mul_res),
        .i_mac     (mac_res),
        .i_clz     (clz_res),
        .i_lrcw    (lrcw_res),
        .i_lfsr    (lfsr_res),
        .o_data    (o_data)
    );

endmodule

/* bit_manip_unit.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"

module bit_manip_unit (
    input  alu_pkg::alu_data_t    i_data_a,
    input  alu_pkg::alu_operand_u i_data_b,
    output alu_pkg::alu_data_t    o_clz,
    output alu_pkg::alu_data_t    o_lrcw,
    output alu_pkg::alu_data_t    o_lfsr
);

    import alu_pkg::*;

    localparam int DW = `ALU_DATA_W;
    localparam int CW = $clog2(DW) + 1;     // counts 0..16
    localparam int SW = `ALU_LFSR_CNT_W;
    localparam logic [SW-1:0] MAX_STEPS = SW'(`ALU_LFSR_MAX_STEPS);

    logic [CW-1:0] clz_cnt;
    logic          clz_hit;
    logic [CW-1:0] pop_cnt;
    alu_data_t     lrcw_val;
    logic [SW-1:0] lfsr_steps;
    alu_data_t     lfsr_val;
    logic          lfsr_fb;

    ////////////////////////////////////////////////////////////
    // count leading zeros
    ////////////////////////////////////////////////////////////
    always_comb begin
        clz_cnt = CW'(DW);      // a == 0
        clz_hit = 1'b0;
        for (int i = DW - 1; i >= 0; i--) begin
            if (!clz_hit && i_data_a[i]) begin
                clz_cnt = CW'(DW - 1 - i);
                clz_hit = 1'b1;
            end
        end
    end

    assign o_clz = {{(DW-CW){1'b0}}, clz_cnt};

    ////////////////////////////////////////////////////////////
    // popcount driven rotate with complement
    ////////////////////////////////////////////////////////////
    always_comb begin
        pop_cnt = '0;
        for (int i = 0; i < DW; i++) begin
            pop_cnt = pop_cnt + CW'(i_data_a[i]);
        end

        lrcw_val = i_data_b;    // whole word of b
        for (int s = 0; s < DW; s++) begin
            if (CW'(s) < pop_cnt) begin
                lrcw_val = {lrcw_val[DW-2:0], ~lrcw_val[DW-1]};
            end
        end
    end

    assign o_lrcw = lrcw_val;

    ////////////////////////////////////////////////////////////
    // lfsr advance
    ////////////////////////////////////////////////////////////
    always_comb begin
        lfsr_steps = i_data_b.ctl.lfsr_steps;
        if (lfsr_steps > MAX_STEPS) begin
            lfsr_steps = MAX_STEPS;
        end

        lfsr_val = i_data_a;
        lfsr_fb  = 1'b0;
        for (int s = 0; s < `ALU_LFSR_MAX_STEPS; s++) begin
            if (SW'(s) < lfsr_steps) begin
                lfsr_fb  = lfsr_val[`ALU_LFSR_TAP_A] ^ lfsr_val[`ALU_LFSR_TAP_B]
                         ^ lfsr_val[`ALU_LFSR_TAP_C] ^ lfsr_val[`ALU_LFSR_TAP_D];
                lfsr_val = {lfsr_val[DW-2:0], lfsr_fb};   // shift in at lsb
            end
        end
    end

    assign o_lfsr = lfsr_val;

endmodule

/* fx_arith_unit.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"

module fx_arith_unit (
    input  alu_pkg::alu_data_t    i_data_a,
    input  alu_pkg::alu_operand_u i_data_b,
    input  alu_pkg::alu_data_t    i_acc,        // previous o_data
    output alu_pkg::alu_data_t    o_add,
    output alu_pkg::alu_data_t    o_sub,
    output alu_pkg::alu_data_t    o_mul,
    output alu_pkg::alu_data_t    o_mac
);

    import alu_pkg::*;

    localparam int DW = `ALU_DATA_W;
    localparam int FW = `ALU_FRAC_W;
    localparam int PW = 2 * DW;         // full product
    localparam int RW = PW - FW + 2;    // rounded value plus guard bit

    localparam alu_data_t SAT_MAX = {1'b0, {(DW-1){1'b1}}};
    localparam alu_data_t SAT_MIN = {1'b1, {(DW-1){1'b0}}};

    alu_data_t            b_word;
    logic signed [DW:0]   add_full;
    logic signed [DW:0]   sub_full;
    logic signed [PW-1:0] mul_full;
    logic signed [PW:0]   mul_ext;
    logic signed [PW:0]   acc_scaled;
    logic signed [PW:0]   mac_full;

    // 17 bit sum back into word range
    function automatic alu_data_t sat_word(input logic signed [DW:0] v);
        alu_data_t r;
        if (v[DW] != v[DW-1]) begin
            r = v[DW] ? SAT_MIN : SAT_MAX;  // sign says which rail
        end else begin
            r = v[DW-1:0];
        end
        return r;
    endfunction

    // drop fraction bits with round half up, then clip
    function automatic alu_data_t round_sat(input logic signed [PW:0] v);
        logic signed [RW-1:0] rnd;
        alu_data_t            r;
        rnd = {v[PW], v[PW:FW]} + {{(RW-1){1'b0}}, v[FW-1]};
        if (rnd[RW-1:DW-1] != {(RW-DW+1){rnd[RW-1]}}) begin
            r = rnd[RW-1] ? SAT_MIN : SAT_MAX;
        end else begin
            r = rnd[DW-1:0];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////
    always_comb begin
        b_word   = alu_data_t'(i_data_b.fx);               // fx view as one word
        add_full = {i_data_a[DW-1], i_data_a} + {b_word[DW-1], b_word};
        sub_full = {i_data_a[DW-1], i_data_a} - {b_word[DW-1], b_word};
        mul_full = PW'(i_data_a) * PW'(b_word);             // Q12.20
        mul_ext  = {mul_full[PW-1], mul_full};

        // accumulator lifted to the product's Q point
        acc_scaled = {{(PW-DW-FW+1){i_acc[DW-1]}}, i_acc, {FW{1'b0}}};
        mac_full   = mul_ext + acc_scaled;
    end

    assign o_add = sat_word(add_full);
    assign o_sub = sat_word(sub_full);
    assign o_mul = round_sat(mul_ext);
    assign o_mac = round_sat(mac_full);

endmodule

/* tb_alu.sv */
`timescale 1ns/1ps
`include "alu_defs.svh"

module tb_alu;

    import alu_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int CADENCE_CYCLES = 12;    // four result periods watched after reset
    localparam int NUM_OPS        = 70;
    localparam int MARGIN_CYCLES  = 40;
    localparam int WATCHDOG_NS    =
        (RESET_CYCLES + CADENCE_CYCLES + 3 * NUM_OPS + MARGIN_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic [15:0] data_a;
    logic [15:0] data_b;
    logic [3:0]  inst;
    logic        valid;
    logic        busy;
    logic [15:0] data;

    integer      seed = 32'h917a;
    logic [15:0] prev;      // expected o_data of the last op, feeds the mac model

    alu_top dut_i (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_data_a (data_a),
        .i_data_b (data_b),
        .i_inst   (inst),
        .o_valid  (valid),
        .o_busy   (busy),
        .o_data   (data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference models
    ////////////////////////////////////////////////////////////
    function automatic longint to_long(input logic [15:0] w);
        return longint'($signed(w));
    endfunction

    function automatic logic [15:0] saturate_word(input longint v);
        if (v > 64'sd32767) begin
            return 16'h7fff;
        end
        if (v < -64'sd32768) begin
            return 16'h8000;
        end
        return v[15:0];
    endfunction

    // q12.20 product down to q6.10, half lsb rounds up
    function automatic logic [15:0] round_product(input longint p);
        longint q;
        q = (p >>> `ALU_FRAC_W) + longint'(p[`ALU_FRAC_W-1]);
        return saturate_word(q);
    endfunction

    function automatic logic [15:0] count_leading_zeros(input logic [15:0] a);
        logic [15:0] w;
        int          n;
        w = a;
        n = 0;
        while (n < 16 && !w[15]) begin
            w = w << 1;
            n++;
        end
        return 16'(n);
    endfunction

    function automatic logic [15:0] rotate_complement(input logic [15:0] a,
                                                      input logic [15:0] b);
        logic [15:0] r;
        r = b;
        for (int i = 0; i < $countones(a); i++) begin
            r = {r[14:0], ~r[15]};  // old msb comes back inverted
        end
        return r;
    endfunction

    function automatic logic [15:0] lfsr_advance(input logic [15:0] a, input logic [3:0] steps);
        logic [15:0] r;
        int          n;
        r = a;
        n = int'(steps);
        if (n > `ALU_LFSR_MAX_STEPS) begin
            n = `ALU_LFSR_MAX_STEPS;
        end
        repeat (n) begin
            r = {r[14:0], r[`ALU_LFSR_TAP_A] ^ r[`ALU_LFSR_TAP_B]
                        ^ r[`ALU_LFSR_TAP_C] ^ r[`ALU_LFSR_TAP_D]};
        end
        return r;
    endfunction

    // random word, arithmetic shift keeps results in range
    function automatic logic [15:0] rand_scaled(input int shift);
        int r;
        r = $random(seed);
        return 16'($signed(r[15:0]) >>> shift);
    endfunction

    ////////////////////////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////////////////////////
    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("error: time %0t, %s = %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic run_op(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b,
                          input logic [15:0] exp);
        while (busy) @(negedge clk);
        inst   = op;            // operands may change while busy is low
        data_a = a;
        data_b = b;
        @(negedge clk);
        while (!valid) @(negedge clk);
        compare("o_data", data, exp);
        prev = exp;
    endtask

    task automatic reset_and_cadence();
        logic low_exp;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        compare("o_busy", 16'(busy), 16'h1);
        compare("o_valid", 16'(valid), 16'h0);
        compare("o_data", data, 16'h0000);
        rst_n = 1'b1;
        while (busy) @(negedge clk);
        // first result is registered but not flagged
        compare("o_valid", 16'(valid), 16'h0);
        compare("o_data", data, 16'h0c00);
        for (int i = 1; i <= CADENCE_CYCLES; i++) begin
            @(negedge clk);
            low_exp = (i % 3 == 0);     // busy drops every third cycle
            compare("o_busy", 16'(busy), 16'(!low_exp));
            compare("o_valid", 16'(valid), 16'(low_exp));
        end
        prev = 16'h0c00;
    endtask

    task automatic add_sub_cases();
        logic [15:0] a;
        logic [15:0] b;
        for (int i = 0; i < 8; i++) begin
            a = rand_scaled(2);
            b = rand_scaled(2);
            run_op(OP_ADD_FX, a, b, saturate_word(to_long(a) + to_long(b)));
            run_op(OP_SUB_FX, a, b, saturate_word(to_long(a) - to_long(b)));
        end
        run_op(OP_ADD_FX, 16'h7000, 16'h2000, 16'h7fff);
        run_op(OP_ADD_FX, 16'h9000, 16'ha000, 16'h8000);
        run_op(OP_SUB_FX, 16'h7000, 16'he000, 16'h7fff);
        run_op(OP_SUB_FX, 16'h8800, 16'h1000, 16'h8000);
    endtask

    task automatic mul_cases();
        logic [15:0] a;
        logic [15:0] b;
        for (int i = 0; i < 8; i++) begin
            a = rand_scaled(3);
            b = rand_scaled(3);
            run_op(OP_MUL_FX, a, b, round_product(to_long(a) * to_long(b)));
        end
        run_op(OP_MUL_FX, 16'h0001, 16'h0200, 16'h0001);     // exact half lsb
        run_op(OP_MUL_FX, 16'hffff, 16'h0200, 16'h0000);
        run_op(OP_MUL_FX, 16'h0003, 16'h0200, 16'h0002);
        run_op(OP_MUL_FX, 16'h4000, 16'h4000, 16'h7fff);     // 16 * 16
        run_op(OP_MUL_FX, 16'h4000, 16'hc000, 16'h8000);
    endtask

    task automatic mac_chain();
        logic [15:0] a;
        logic [15:0] b;
        run_op(OP_ADD_FX, 16'h0000, 16'h0000, 16'h0000);     // clear accumulator
        for (int i = 0; i < 6; i++) begin
            a = rand_scaled(3);
            b = rand_scaled(3);
            run_op(OP_MAC, a, b, round_product(to_long(a) * to_long(b) + (to_long(prev) <<< 10)));
        end
        run_op(OP_MAC, 16'h4000, 16'h4000, 16'h7fff);        // past the rail for any acc
        run_op(OP_MAC, 16'h0400, 16'h0400, 16'h7fff);        // stays on the rail
        run_op(OP_MAC, 16'hc000, 16'h7000, 16'h8000);
    endtask

    task automatic bit_op_cases();
        logic [15:0] a;
        logic [15:0] b;
        logic [3:0]  steps [3] = '{4'd0, 4'd8, 4'd15};
        for (int i = 0; i < 6; i++) begin
            a = rand_scaled(0) >> (i * 2);
            b = rand_scaled(0);
            run_op(OP_CLZ, a, b, count_leading_zeros(a));
        end
        run_op(OP_CLZ, 16'h0000, 16'h1234, 16'd16);
        run_op(OP_CLZ, 16'h8000, 16'h1234, 16'd0);
        for (int i = 0; i < 6; i++) begin
            a = rand_scaled(0);
            b = rand_scaled(0);
            run_op(OP_LRCW, a, b, rotate_complement(a, b));
        end
        for (int i = 0; i < 6; i++) begin
            a = rand_scaled(0);
            b = rand_scaled(0);
            run_op(OP_LFSR, a, b, lfsr_advance(a, b[3:0]));
        end
        for (int k = 0; k < 3; k++) begin
            a = rand_scaled(0);
            b = rand_scaled(0);
            b[3:0] = steps[k];
            run_op(OP_LFSR, a, b, lfsr_advance(a, steps[k]));
        end
    endtask

    task automatic unused_opcodes();
        logic [3:0] codes [4] = '{4'd4, 4'd8, 4'd9, 4'd15};
        for (int k = 0; k < 4; k++) begin
            run_op(codes[k], rand_scaled(0), rand_scaled(0), 16'h0000);
        end
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        data_a = 16'h0400;      // 1.0 + 2.0 held through the first cycle
        data_b = 16'h0800;
        inst   = OP_ADD_FX;
        prev   = 16'h0000;
        reset_and_cadence();
        add_sub_cases();
        mul_cases();
        mac_chain();
        bit_op_cases();
        unused_opcodes();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
alu_pkg.sv
alu_sequencer.sv
fx_arith_unit.sv
bit_manip_unit.sv
alu_result_stage.sv
alu_top.sv
tb_alu.sv
